// File: graph_algorithm_control.sv
`include "graph_settings.svh"

module graph_algorithm_control
	import graph_pkg::*;
#(
	parameter int NUM_CU = `NUM_VERTEX_CU
) (
	input  logic    clock,
	input  logic    rstn,
	input  wb_req_t host_req,
	output wb_rsp_t host_rsp,
	output wb_req_t res_req,
	input  wb_rsp_t res_rsp,
	output logic    done
);

	logic job_valid;
	logic job_pop;
	vertex_job_t job;
	vertex_id_t vertex_count;
	logic run_start;

	logic [NUM_CU-1:0] cu_start;
	logic [NUM_CU-1:0] cu_busy;
	vertex_job_t cu_job;

	logic [NUM_CU-1:0] result_valid;
	logic [NUM_CU-1:0] result_taken;
	vertex_result_t results [NUM_CU];

	////////////////////////////////////////
	// Intake and dispatch
	////////////////////////////////////////

	vertex_job_intake u_intake (
		.clock       (clock),
		.rstn        (rstn),
		.host_req    (host_req),
		.host_rsp    (host_rsp),
		.job_pop     (job_pop),
		.job_valid   (job_valid),
		.job         (job),
		.vertex_count(vertex_count),
		.run_start   (run_start)
	);

	vertex_job_arbiter #(.NUM_CU(NUM_CU)) u_arbiter (
		.clock    (clock),
		.rstn     (rstn),
		.job_valid(job_valid),
		.job      (job),
		.job_pop  (job_pop),
		.cu_busy  (cu_busy),
		.cu_start (cu_start),
		.cu_job   (cu_job)
	);

	////////////////////////////////////////
	// Compute units and write-out
	////////////////////////////////////////

	for (genvar i = 0; i < NUM_CU; i++) begin : g_cu
		vertex_pagerank_cu u_cu (
			.clock       (clock),
			.rstn        (rstn),
			.start       (cu_start[i]),
			.job_in      (cu_job),
			.busy        (cu_busy[i]),
			.result_valid(result_valid[i]),
			.result      (results[i]),
			.result_taken(result_taken[i])
		);
	end

	vertex_result_collector #(.NUM_CU(NUM_CU)) u_collector (
		.clock       (clock),
		.rstn        (rstn),
		.result_valid(result_valid),
		.results     (results),
		.result_taken(result_taken),
		.res_req     (res_req),
		.res_rsp     (res_rsp),
		.vertex_count(vertex_count),
		.run_start   (run_start),
		.done        (done)
	);

endmodule

// File: graph_chk.sv
module graph_chk
	import graph_pkg::*;
(
	input logic    clock,
	input logic    rstn,
	input wb_req_t host_req,
	input wb_rsp_t host_rsp,
	input wb_req_t res_req,
	input wb_rsp_t res_rsp,
	input logic    run_start,
	input logic    done
);

	////////////////////////////////////////
	// Wishbone classic rules
	////////////////////////////////////////

	a_host_stb_cyc: assert property (@(posedge clock) disable iff (!rstn)
		host_req.stb |-> host_req.cyc)
		else $error("host_req.stb is high without cyc");

	a_res_stb_cyc: assert property (@(posedge clock) disable iff (!rstn)
		res_req.stb |-> res_req.cyc)
		else $error("res_req.stb is high without cyc");

	// Master holds the write until the sink answers
	a_res_stable: assert property (@(posedge clock) disable iff (!rstn)
		res_req.stb && !res_rsp.ack |=> $stable(res_req.adr) && $stable(res_req.dat))
		else $error("res_req address or data changed before ack");

	a_host_ack_stb: assert property (@(posedge clock) disable iff (!rstn)
		host_rsp.ack |-> host_req.cyc && host_req.stb)
		else $error("host_rsp.ack without a host strobe");

	////////////////////////////////////////
	// Completion flag
	////////////////////////////////////////

	a_done_sticky: assert property (@(posedge clock) disable iff (!rstn)
		$fell(done) |-> $past(run_start))
		else $error("done fell without a settings write");

endmodule

bind graph_algorithm_control graph_chk u_chk (
	.clock    (clock),
	.rstn     (rstn),
	.host_req (host_req),
	.host_rsp (host_rsp),
	.res_req  (res_req),
	.res_rsp  (res_rsp),
	.run_start(run_start),
	.done     (done)
);

// File: graph_pkg.sv
`include "graph_settings.svh"

package graph_pkg;

	////////////////////////////////////////
	// Scalar types
	////////////////////////////////////////

	typedef logic [`VERTEX_ID_BITS-1:0] vertex_id_t;
	typedef logic [`DEGREE_BITS-1:0] degree_t;
	// Rank and contribution share a format
	typedef logic [`RANK_BITS-1:0] rank_t;
	typedef logic [`WB_ADR_BITS-1:0] wb_adr_t;
	typedef logic [`WB_DAT_BITS-1:0] wb_dat_t;

	////////////////////////////////////////
	// Pipeline payloads
	////////////////////////////////////////

	typedef struct packed {
		vertex_id_t vertex_id;
		degree_t out_degree;
		rank_t rank;
	} vertex_job_t;

	typedef struct packed {
		vertex_id_t vertex_id;
		rank_t contribution;
	} vertex_result_t;

	// Wishbone classic, master to slave and back
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		wb_dat_t dat;
	} wb_rsp_t;

	typedef enum logic [1:0] {CU_IDLE, CU_DIVIDE, CU_RESULT} cu_state_t;
	typedef enum logic {COL_IDLE, COL_WRITE} collect_state_t;

	// Host register map
	localparam wb_adr_t SETTINGS_ADR = 16'd0;
	localparam wb_adr_t JOB_ADR = 16'd1;

endpackage

// File: graph_settings.svh
`ifndef GRAPH_SETTINGS_SVH
`define GRAPH_SETTINGS_SVH

////////////////////////////////////////
// Pipeline sizing
////////////////////////////////////////

// Compute units behind the arbiter
`define NUM_VERTEX_CU 4
// Jobs buffered between host and arbiter
`define JOB_FIFO_DEPTH 8

////////////////////////////////////////
// Field and bus widths
////////////////////////////////////////

`define VERTEX_ID_BITS 16
`define DEGREE_BITS 8
`define RANK_BITS 16
`define WB_ADR_BITS 16
`define WB_DAT_BITS 32

`endif

// File: tb.f
+incdir+.
graph_pkg.sv
vertex_job_intake.sv
vertex_job_arbiter.sv
vertex_pagerank_cu.sv
vertex_result_collector.sv
graph_algorithm_control.sv
graph_chk.sv
tb_graph_algorithm_control.sv

// File: tb_graph_algorithm_control.sv
`include "graph_settings.svh"

module tb_graph_algorithm_control
	import graph_pkg::*;
();

	localparam int RUN1_JOBS = 64;
	localparam int RUN2_JOBS = 20;
	localparam int WATCHDOG_CYCLES = (RUN1_JOBS + RUN2_JOBS) * 200 + 1000;

	logic clock;
	logic rstn;
	wb_req_t host_req;
	wb_rsp_t host_rsp;
	wb_req_t res_req;
	wb_rsp_t res_rsp;
	logic done;

	integer seed;
	int value_errors;
	int other_errors;
	int writes_seen;
	// Model of one run, indexed by the 8 bit id that fits on the host bus
	rank_t exp_contrib [256];
	bit exp_known [256];
	bit written [256];
	int run_n;
	int ack_total;
	int ack_lag;
	bit done_check_en;
	bit slow_sink;
	int stalls;

	graph_algorithm_control #(.NUM_CU(`NUM_VERTEX_CU)) UUT (
		.clock   (clock),
		.rstn    (rstn),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.res_req (res_req),
		.res_rsp (res_rsp),
		.done    (done)
	);

	always #5 clock = ~clock;

	function automatic int rand_upto(input int max);
		return $unsigned($random(seed)) % (max + 1);
	endfunction

	task automatic check_result(input vertex_id_t id, input rank_t got, input rank_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] res_req.dat for vertex %h: got %h, expected %h", id, got, exp);
		end
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] done at %0t: got %h, expected %h", $time, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Host side
	////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// Classic write, held until ack
	task automatic host_write(input wb_adr_t adr, input wb_dat_t dat, output int waited);
		host_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		waited = 0;
		@(posedge clock);
		while (!host_rsp.ack) begin
			waited++;
			@(posedge clock);
		end
		if (host_rsp.dat !== '0) begin
			value_errors++;
			$display("[FAIL] host_rsp.dat: got %h, expected %h", host_rsp.dat, wb_dat_t'(0));
		end
		#1;
		host_req = '0;
	endtask

	task automatic run_jobs(input int n_jobs, input int max_gap);
		int waited;
		int id;
		degree_t degree;
		rank_t rank;
		done_check_en = 1'b0;
		for (int i = 0; i < 256; i++) begin
			exp_known[i] = 1'b0;
			written[i] = 1'b0;
		end
		host_write(SETTINGS_ADR, wb_dat_t'(n_jobs), waited);
		run_n = n_jobs;
		ack_total = 0;
		ack_lag = 0;
		stalls = 0;
		done_check_en = 1'b1;
		for (int j = 0; j < n_jobs; j++) begin
			// Redraw until an unused id comes up
			id = rand_upto(255);
			while (exp_known[id]) begin
				id = rand_upto(255);
			end
			degree = (rand_upto(7) == 0) ? '0 : degree_t'(rand_upto(254) + 1);
			rank = rank_t'(rand_upto(65535));
			exp_known[id] = 1'b1;
			exp_contrib[id] = (degree == '0) ? '0 : rank / degree;
			host_write(JOB_ADR, {id[7:0], degree, rank}, waited);
			if (waited > 1) begin
				stalls++;
			end
			idle_cycles(rand_upto(max_gap));
		end
		while (!done) begin
			@(posedge clock);
		end
		#1;
		// Quiet window for late or repeated writes
		idle_cycles(100);
		check_done(done, 1'b1);
		for (int i = 0; i < 256; i++) begin
			if (exp_known[i] && !written[i]) begin
				other_errors++;
				$display("Vertex %h was never written out", i);
			end
		end
	endtask

	////////////////////////////////////////
	// Result side
	////////////////////////////////////////

	always begin : result_sink
		int delay;
		@(posedge clock);
		if (rstn && res_req.cyc && res_req.stb) begin
			delay = slow_sink ? 5 : rand_upto(5);
			repeat (delay) @(posedge clock);
			#1;
			res_rsp.ack = 1'b1;
			@(posedge clock);
			#1;
			res_rsp.ack = 1'b0;
		end
	end

	always @(posedge clock) begin : result_monitor
		int idx;
		// done follows the write count two edges late
		if (done_check_en) begin
			check_done(done, ack_lag >= run_n);
			ack_lag = ack_total;
		end
		if (rstn && res_req.stb && res_rsp.ack) begin
			idx = int'(res_req.adr);
			writes_seen++;
			if (res_req.we !== 1'b1) begin
				value_errors++;
				$display("[FAIL] res_req.we: got %h, expected 1", res_req.we);
			end
			if (idx > 255 || !exp_known[idx]) begin
				other_errors++;
				$display("Write to vertex %h, which no job of this run carries", res_req.adr);
			end else if (written[idx]) begin
				other_errors++;
				$display("Vertex %h was written a second time", res_req.adr);
			end else begin
				written[idx] = 1'b1;
				check_result(res_req.adr, res_req.dat[15:0], exp_contrib[idx]);
				if (res_req.dat[31:16] !== '0) begin
					value_errors++;
					$display("[FAIL] res_req.dat upper half: got %h, expected 0000",
						res_req.dat[31:16]);
				end
			end
			ack_total++;
		end
	end

	////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////

	initial begin
		seed = 32'h6b2b160c;
		clock = 1'b0;
		rstn = 1'b0;
		host_req = '0;
		res_rsp = '0;
		value_errors = 0;
		other_errors = 0;
		writes_seen = 0;
		run_n = 0;
		ack_total = 0;
		ack_lag = 0;
		done_check_en = 1'b0;
		slow_sink = 1'b0;
		stalls = 0;
		repeat (8) @(posedge clock);
		#1;
		rstn = 1'b1;
		idle_cycles(2);
		check_done(done, 1'b0);
		if (res_req.cyc !== 1'b0) begin
			value_errors++;
			$display("[FAIL] res_req.cyc after reset: got %h, expected 0", res_req.cyc);
		end
		if (host_rsp.ack !== 1'b0) begin
			value_errors++;
			$display("[FAIL] host_rsp.ack after reset: got %h, expected 0", host_rsp.ack);
		end
		run_jobs(RUN1_JOBS, 3);
		// Second run against a sink that always waits 5 cycles
		slow_sink = 1'b1;
		run_jobs(RUN2_JOBS, 0);
		if (stalls == 0) begin
			other_errors++;
			$display("Host writes never stalled under the slow result sink");
		end
		$display("Summary: %0d result writes, %0d value errors, %0d other errors",
			writes_seen, value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Timeout after %0d cycles: %0d result writes, %0d value errors, %0d other",
			WATCHDOG_CYCLES, writes_seen, value_errors, other_errors);
		$display("tests failed");
		$finish;
	end

endmodule

// File: vertex_job_arbiter.sv
`include "graph_settings.svh"

module vertex_job_arbiter
	import graph_pkg::*;
#(
	parameter int NUM_CU = `NUM_VERTEX_CU
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              job_valid,
	input  vertex_job_t       job,
	output logic              job_pop,
	input  logic [NUM_CU-1:0] cu_busy,
	output logic [NUM_CU-1:0] cu_start,
	output vertex_job_t       cu_job
);

	localparam int IDX_BITS = (NUM_CU > 1) ? $clog2(NUM_CU) : 1;

	logic [NUM_CU-1:0] idle;
	logic [NUM_CU-1:0] grant;
	logic [IDX_BITS-1:0] last_grant;
	logic [IDX_BITS-1:0] grant_idx;

	// A unit raises busy one cycle after its start, so hide it meanwhile
	assign idle = ~cu_busy & ~cu_start;
	assign job_pop = job_valid && (|idle);

	// First idle unit after the previous grant
	always_comb begin
		int idx;
		logic found;
		grant = '0;
		grant_idx = last_grant;
		found = 1'b0;
		for (int i = 1; i <= NUM_CU; i++) begin
			idx = (int'(last_grant) + i) % NUM_CU;
			if (!found && idle[idx]) begin
				found = 1'b1;
				grant[idx] = 1'b1;
				grant_idx = IDX_BITS'(idx);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_start <= '0;
			last_grant <= IDX_BITS'(NUM_CU - 1);
		end else begin
			cu_start <= job_pop ? grant : '0;
			if (job_pop) begin
				last_grant <= grant_idx;
			end
		end
	end

	// Broadcast job, only the started unit latches it
	always_ff @(posedge clock) begin
		if (job_pop) begin
			cu_job <= job;
		end
	end

endmodule

// File: vertex_job_intake.sv
`include "graph_settings.svh"

module vertex_job_intake
	import graph_pkg::*;
#(
	parameter int DEPTH = `JOB_FIFO_DEPTH
) (
	input  logic        clock,
	input  logic        rstn,
	input  wb_req_t     host_req,
	output wb_rsp_t     host_rsp,
	input  logic        job_pop,
	output logic        job_valid,
	output vertex_job_t job,
	output vertex_id_t  vertex_count,
	output logic        run_start
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);
	localparam int PAD_BITS = $bits(vertex_job_t) - $bits(wb_dat_t);

	vertex_job_t mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] fill;
	logic fifo_full;
	logic host_ack;
	logic bus_req;
	logic accept;
	logic settings_wr;
	logic push;
	vertex_job_t job_word;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	////////////////////////////////////////
	// Host bus decode
	////////////////////////////////////////

	// New request only while the previous ack is not on the bus
	assign bus_req = host_req.cyc && host_req.stb && !host_ack;
	assign fifo_full = (fill == CNT_BITS'(DEPTH));
	// Job writes stall the host while the FIFO is full
	assign accept = bus_req && !(host_req.we && host_req.adr == JOB_ADR && fifo_full);
	assign settings_wr = accept && host_req.we && host_req.adr == SETTINGS_ADR;
	assign push = accept && host_req.we && host_req.adr == JOB_ADR;
	// Upper vertex id bits lie beyond the data bus and read as zero
	assign job_word = {{PAD_BITS{1'b0}}, host_req.dat};

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			host_ack <= 1'b0;
			run_start <= 1'b0;
			vertex_count <= '0;
		end else begin
			host_ack <= accept;
			run_start <= settings_wr;
			if (settings_wr) begin
				vertex_count <= host_req.dat[$bits(vertex_id_t)-1:0];
			end
		end
	end

	assign host_rsp = '{ack: host_ack, dat: '0};

	////////////////////////////////////////
	// Job FIFO
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (job_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (push && !job_pop) begin
				fill <= fill + 1'b1;
			end else if (!push && job_pop) begin
				fill <= fill - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= job_word;
		end
	end

	assign job_valid = (fill != '0);
	assign job = mem[rd_ptr];

endmodule

// File: vertex_pagerank_cu.sv
`include "graph_settings.svh"

module vertex_pagerank_cu
	import graph_pkg::*;
(
	input  logic           clock,
	input  logic           rstn,
	input  logic           start,
	input  vertex_job_t    job_in,
	output logic           busy,
	output logic           result_valid,
	output vertex_result_t result,
	input  logic           result_taken
);

	localparam int REM_BITS = `DEGREE_BITS + 1;
	localparam int STEP_BITS = $clog2(`RANK_BITS);
	localparam int Q_BITS = $bits(rank_t);

	cu_state_t state;
	logic [STEP_BITS-1:0] step;
	vertex_id_t vertex_id;
	degree_t divisor;
	rank_t quotient;
	degree_t remainder;
	logic [REM_BITS-1:0] shifted;
	logic [REM_BITS:0] trial;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= CU_IDLE;
			step <= '0;
		end else begin
			case (state)
				CU_IDLE: begin
					if (start) begin
						state <= CU_DIVIDE;
						step <= '0;
					end
				end
				CU_DIVIDE: begin
					step <= step + 1'b1;
					// One quotient bit per cycle
					if (step == STEP_BITS'(`RANK_BITS - 1)) begin
						state <= CU_RESULT;
					end
				end
				CU_RESULT: begin
					if (result_taken) begin
						state <= CU_IDLE;
					end
				end
				default: state <= CU_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Restoring divider
	////////////////////////////////////////

	// Remainder stays below the divisor, so it fits the degree width
	assign shifted = {remainder, quotient[Q_BITS-1]};
	assign trial = {1'b0, shifted} - {2'b00, divisor};

	always_ff @(posedge clock) begin
		if (state == CU_IDLE && start) begin
			vertex_id <= job_in.vertex_id;
			divisor <= job_in.out_degree;
			quotient <= job_in.rank;
			remainder <= '0;
		end else if (state == CU_DIVIDE) begin
			if (!trial[REM_BITS]) begin
				remainder <= trial[REM_BITS-2:0];
				quotient <= {quotient[Q_BITS-2:0], 1'b1};
			end else begin
				remainder <= shifted[REM_BITS-2:0];
				quotient <= {quotient[Q_BITS-2:0], 1'b0};
			end
		end
	end

	assign busy = (state != CU_IDLE);
	assign result_valid = (state == CU_RESULT);
	// Zero out-degree gives no contribution
	assign result = '{vertex_id: vertex_id, contribution: (divisor == '0) ? '0 : quotient};

endmodule

// File: vertex_result_collector.sv
`include "graph_settings.svh"

module vertex_result_collector
	import graph_pkg::*;
#(
	parameter int NUM_CU = `NUM_VERTEX_CU
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic [NUM_CU-1:0] result_valid,
	input  vertex_result_t    results [NUM_CU],
	output logic [NUM_CU-1:0] result_taken,
	output wb_req_t           res_req,
	input  wb_rsp_t           res_rsp,
	input  vertex_id_t        vertex_count,
	input  logic              run_start,
	output logic              done
);

	localparam int IDX_BITS = (NUM_CU > 1) ? $clog2(NUM_CU) : 1;
	localparam int PAD_BITS = $bits(wb_dat_t) - $bits(rank_t);

	collect_state_t state;
	logic [NUM_CU-1:0] pick;
	logic [IDX_BITS-1:0] pick_idx;
	logic [IDX_BITS-1:0] last_pick;
	logic any_valid;
	logic req_active;
	logic write_acked;
	vertex_result_t pending;
	vertex_id_t ack_count;
	logic run_valid;

	// Next unit holding a result after the last one served
	always_comb begin
		int idx;
		pick = '0;
		pick_idx = last_pick;
		any_valid = 1'b0;
		for (int i = 1; i <= NUM_CU; i++) begin
			idx = (int'(last_pick) + i) % NUM_CU;
			if (!any_valid && result_valid[idx]) begin
				any_valid = 1'b1;
				pick[idx] = 1'b1;
				pick_idx = IDX_BITS'(idx);
			end
		end
	end

	////////////////////////////////////////
	// Wishbone master write
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= COL_IDLE;
			last_pick <= IDX_BITS'(NUM_CU - 1);
			result_taken <= '0;
			req_active <= 1'b0;
		end else begin
			result_taken <= '0;
			case (state)
				COL_IDLE: begin
					if (any_valid) begin
						result_taken <= pick;
						last_pick <= pick_idx;
						state <= COL_WRITE;
					end
				end
				COL_WRITE: begin
					// Request goes out the cycle after the take pulse
					if (!req_active) begin
						req_active <= 1'b1;
					end else if (res_rsp.ack) begin
						req_active <= 1'b0;
						state <= COL_IDLE;
					end
				end
				default: state <= COL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == COL_IDLE && any_valid) begin
			pending <= results[pick_idx];
		end
	end

	assign res_req = '{cyc: req_active, stb: req_active, we: req_active,
		adr: pending.vertex_id, dat: {{PAD_BITS{1'b0}}, pending.contribution}};
	assign write_acked = req_active && res_rsp.ack;

	////////////////////////////////////////
	// Completion count
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ack_count <= '0;
			run_valid <= 1'b0;
			done <= 1'b0;
		end else if (run_start) begin
			ack_count <= '0;
			run_valid <= 1'b1;
			done <= 1'b0;
		end else begin
			if (write_acked) begin
				ack_count <= ack_count + 1'b1;
			end
			// Sticky until the next settings write
			if (run_valid && ack_count == vertex_count) begin
				done <= 1'b1;
			end
		end
	end

endmodule
